/* Makefile */
# Verilator build for the sonic VC layer and its testbench

VERILATOR ?= verilator
TOP       ?= tb_sonic_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
LINT_OPTS ?= --lint-only --timing --assert
SIM_OPTS  ?= --binary --timing --assert
PASS_MSG  := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_OPTS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_OPTS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o sim_$(TOP)
	./$(BUILD_DIR)/sim_$(TOP) | tee $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
+incdir+.
sonic_stream_pkg.sv
sonic_link_pkg.sv
sonic_tx_port_fifo.sv
sonic_tx_vc_arbiter.sv
sonic_rx_vc_router.sv
sonic_top.sv
tb_sonic_top.sv

/* sonic_defines.svh */
// beat widths, transmit buffer depth, receive credits and the VC1 TLP type code
`ifndef SONIC_DEFINES_SVH
`define SONIC_DEFINES_SVH

// payload of one stream beat
`define SONIC_DATA_W 128

// unused qwords in the last beat of a packet
`define SONIC_EMPTY_W 2

// beats per transmit buffer, also the credits a transmit port starts with
`define SONIC_TX_FIFO_DEPTH 8

// beats the router may send a receive port before credit comes back
`define SONIC_RX_PORT_CREDITS 4

// TLP type that selects virtual channel 1
`define SONIC_TLP_TYPE_VC1 5'd5

`endif

/* sonic_link_pkg.sv */
// port identifier type and per-port credit return struct
package sonic_link_pkg;

   // which application port a packet belongs to
   typedef logic port_id_t;

   // one credit pulse per port, one beat each
   typedef struct packed {
      logic port1;
      logic port0;
   } credit_ret_t;

endpackage

/* sonic_rx_vc_router.sv */
// sop type decode and credit-gated registered split of core rx to two ports
`timescale 1ns/10ps

module sonic_rx_vc_router (
   input  logic                           pld_clk,
   input  logic                           rst_n,
   input  sonic_stream_pkg::stream_beat_t core_rx_beat,
   input  logic                           core_rx_valid,
   output logic                           core_rx_ready,
   output sonic_stream_pkg::stream_beat_t rx_port_beat,
   output logic [1:0]                     rx_port_valid,
   input  sonic_link_pkg::credit_ret_t    rx_credit
);

`include "sonic_defines.svh"

   localparam int CREDITS = `SONIC_RX_PORT_CREDITS;
   localparam int CNT_W   = $clog2(CREDITS) + 1;
   localparam logic [CNT_W-1:0] CNT_INIT = CREDITS[CNT_W-1:0];

   sonic_stream_pkg::tlp_dw0_u dw0;
   sonic_link_pkg::port_id_t   sop_dest;
   sonic_link_pkg::port_id_t   dest_q;    // channel of the packet in flight
   sonic_link_pkg::port_id_t   dest;
   logic [CNT_W-1:0]           cnt [2];
   logic [1:0]                 has_credit;
   logic [1:0]                 take;
   logic [1:0]                 ret;
   logic                       accept;

   assign dw0.raw  = core_rx_beat.data[31:0];
   assign sop_dest = (dw0.hdr.tlp_type == `SONIC_TLP_TYPE_VC1);
   assign dest     = core_rx_beat.sop ? sop_dest : dest_q;

   assign has_credit[0] = (cnt[0] != '0);
   assign has_credit[1] = (cnt[1] != '0);
   assign ret           = {rx_credit.port1, rx_credit.port0};

   // output register drains every cycle so only credit limits ready
   assign core_rx_ready = has_credit[dest];
   assign accept        = core_rx_valid & core_rx_ready;
   assign take[0]       = accept & ~dest;
   assign take[1]       = accept & dest;

   always_ff @(posedge pld_clk) begin
      if (!rst_n) begin
         dest_q <= 1'b0;
      end else if (accept && core_rx_beat.sop) begin
         dest_q <= sop_dest;
      end
   end

   always_ff @(posedge pld_clk) begin
      if (!rst_n) begin
         for (int p = 0; p < 2; p++) begin
            cnt[p] <= CNT_INIT;
         end
      end else begin
         for (int p = 0; p < 2; p++) begin
            case ({take[p], ret[p]})
               2'b10:   cnt[p] <= cnt[p] - 1'b1;
               2'b01:   cnt[p] <= cnt[p] + 1'b1;
               default: ;  // spend and return cancel
            endcase
         end
      end
   end

   // delivery stage
   always_ff @(posedge pld_clk) begin
      if (accept) begin
         rx_port_beat <= core_rx_beat;
      end
   end

   always_ff @(posedge pld_clk) begin
      if (!rst_n) begin
         rx_port_valid <= '0;
      end else begin
         rx_port_valid <= take;
      end
   end

   // a delivery on a zero count wraps, a surplus return overshoots
   a_credit_range: assert property (
      @(posedge pld_clk) disable iff (!rst_n)
      cnt[0] <= CNT_INIT && cnt[1] <= CNT_INIT
   ) else $error("rx credit counter out of range");

endmodule

/* sonic_stream_pkg.sv */
// stream beat struct, TLP header dword 0 fields and its raw/header union
`include "sonic_defines.svh"

package sonic_stream_pkg;

   // one 128-bit beat with its packet framing, 133 bits
   typedef struct packed {
      logic [`SONIC_DATA_W-1:0]  data;
      logic                      sop;
      logic                      eop;
      logic [`SONIC_EMPTY_W-1:0] empty;  // unused qwords in last beat
      logic                      err;
   } stream_beat_t;

   // header dword 0 as it sits in data[31:0] of a sop beat
   typedef struct packed {
      logic [2:0] fmt;
      logic [4:0] tlp_type;  // byte 0, low five bits
      logic       rsvd0;
      logic [2:0] tc;
      logic [3:0] rsvd1;
      logic       td;
      logic       ep;
      logic [1:0] attr;
      logic [1:0] at;
      logic [9:0] length;    // in dwords
   } tlp_hdr_dw0_t;

   typedef union packed {
      logic [31:0]  raw;
      tlp_hdr_dw0_t hdr;
   } tlp_dw0_u;

endpackage

/* sonic_top.sv */
// top level with two tx port buffers, the tx VC arbiter and the rx VC router
`timescale 1ns/10ps

module sonic_top (
   input  logic                           pld_clk,
   input  logic                           rst_n,
   // application transmit ports
   input  logic [1:0]                     tx_port_valid,
   input  sonic_stream_pkg::stream_beat_t tx_port_beat0,
   input  sonic_stream_pkg::stream_beat_t tx_port_beat1,
   output logic [1:0]                     tx_credit,
   // core transmit stream
   output sonic_stream_pkg::stream_beat_t core_tx_beat,
   output logic                           core_tx_valid,
   output sonic_link_pkg::port_id_t       core_tx_chan,
   input  logic                           core_tx_ready,
   // core receive stream
   input  sonic_stream_pkg::stream_beat_t core_rx_beat,
   input  logic                           core_rx_valid,
   output logic                           core_rx_ready,
   // application receive ports
   output sonic_stream_pkg::stream_beat_t rx_port_beat,
   output logic [1:0]                     rx_port_valid,
   input  sonic_link_pkg::credit_ret_t    rx_credit
);

   sonic_stream_pkg::stream_beat_t head_beat0;
   sonic_stream_pkg::stream_beat_t head_beat1;
   logic [1:0]                     head_valid;
   logic [1:0]                     pop;

   sonic_tx_port_fifo tx_fifo0 (
      .pld_clk    (pld_clk),
      .rst_n      (rst_n),
      .push       (tx_port_valid[0]),
      .push_beat  (tx_port_beat0),
      .pop        (pop[0]),
      .head_beat  (head_beat0),
      .head_valid (head_valid[0]),
      .credit     (tx_credit[0])
   );

   sonic_tx_port_fifo tx_fifo1 (
      .pld_clk    (pld_clk),
      .rst_n      (rst_n),
      .push       (tx_port_valid[1]),
      .push_beat  (tx_port_beat1),
      .pop        (pop[1]),
      .head_beat  (head_beat1),
      .head_valid (head_valid[1]),
      .credit     (tx_credit[1])
   );

   sonic_tx_vc_arbiter tx_arb (
      .pld_clk       (pld_clk),
      .rst_n         (rst_n),
      .head_beat0    (head_beat0),
      .head_beat1    (head_beat1),
      .head_valid    (head_valid),
      .pop           (pop),
      .core_tx_beat  (core_tx_beat),
      .core_tx_valid (core_tx_valid),
      .core_tx_chan  (core_tx_chan),
      .core_tx_ready (core_tx_ready)
   );

   sonic_rx_vc_router rx_rtr (
      .pld_clk       (pld_clk),
      .rst_n         (rst_n),
      .core_rx_beat  (core_rx_beat),
      .core_rx_valid (core_rx_valid),
      .core_rx_ready (core_rx_ready),
      .rx_port_beat  (rx_port_beat),
      .rx_port_valid (rx_port_valid),
      .rx_credit     (rx_credit)
   );

endmodule

/* sonic_tx_port_fifo.sv */
// per-port transmit beat buffer with one credit pulse per popped beat
`timescale 1ns/10ps

module sonic_tx_port_fifo (
   input  logic                           pld_clk,
   input  logic                           rst_n,
   input  logic                           push,
   input  sonic_stream_pkg::stream_beat_t push_beat,
   input  logic                           pop,
   output sonic_stream_pkg::stream_beat_t head_beat,
   output logic                           head_valid,
   output logic                           credit
);

`include "sonic_defines.svh"

   localparam int DEPTH = `SONIC_TX_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam logic [PTR_W:0] FULL_CNT = DEPTH[PTR_W:0];

   sonic_stream_pkg::stream_beat_t mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             full;
   logic             do_pop;

   assign full       = (count == FULL_CNT);
   assign head_valid = (count != '0);
   assign head_beat  = mem[rd_ptr];
   assign do_pop     = pop & head_valid;

   always_ff @(posedge pld_clk) begin
      if (push) begin
         mem[wr_ptr] <= push_beat;
      end
   end

   always_ff @(posedge pld_clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         credit <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
         credit <= do_pop;  // one cycle after the pop
      end
   end

   // port spent more credits than it was given
   a_no_push_when_full: assert property (
      @(posedge pld_clk) disable iff (!rst_n) push |-> !full
   ) else $error("tx fifo push while full");

endmodule

/* sonic_tx_vc_arbiter.sv */
// packet-level round-robin merge of two port buffers onto the core tx stream
`timescale 1ns/10ps

module sonic_tx_vc_arbiter (
   input  logic                           pld_clk,
   input  logic                           rst_n,
   input  sonic_stream_pkg::stream_beat_t head_beat0,
   input  sonic_stream_pkg::stream_beat_t head_beat1,
   input  logic [1:0]                     head_valid,
   output logic [1:0]                     pop,
   output sonic_stream_pkg::stream_beat_t core_tx_beat,
   output logic                           core_tx_valid,
   output sonic_link_pkg::port_id_t       core_tx_chan,
   input  logic                           core_tx_ready
);

   sonic_link_pkg::port_id_t grant;     // locked owner of the open packet
   sonic_link_pkg::port_id_t last_win;  // owner of the previous packet
   sonic_link_pkg::port_id_t pick;
   sonic_link_pkg::port_id_t sel;
   logic                     pkt_open;
   logic                     xfer;
   logic                     pkt_done;

   // choice at a packet boundary
   always_comb begin
      if (head_valid == 2'b11) begin
         pick = ~last_win;  // take turns when both wait
      end else begin
         pick = head_valid[1];
      end
   end

   assign sel           = pkt_open ? grant : pick;
   assign core_tx_valid = head_valid[sel];
   assign core_tx_beat  = sel ? head_beat1 : head_beat0;
   assign core_tx_chan  = sel;

   assign xfer     = core_tx_valid & core_tx_ready;
   assign pkt_done = xfer & core_tx_beat.eop;
   assign pop[0]   = xfer & ~sel;
   assign pop[1]   = xfer & sel;

   always_ff @(posedge pld_clk) begin
      if (!rst_n) begin
         grant    <= 1'b0;
         last_win <= 1'b1;  // port 0 goes first
         pkt_open <= 1'b0;
      end else begin
         // lock as soon as a sop is shown so a stall cannot switch ports
         if (core_tx_valid && !pkt_open) begin
            grant    <= sel;
            pkt_open <= 1'b1;
         end
         if (pkt_done) begin
            pkt_open <= 1'b0;
            last_win <= sel;
         end
      end
   end

   // no interleaving between sop and eop
   a_grant_held: assert property (
      @(posedge pld_clk) disable iff (!rst_n)
      xfer && !core_tx_beat.eop |=> $stable(core_tx_chan)
   ) else $error("tx grant changed inside a packet");

   // stalled beat must be presented again unchanged
   a_stall_hold: assert property (
      @(posedge pld_clk) disable iff (!rst_n)
      core_tx_valid && !core_tx_ready |=>
         core_tx_valid && $stable(core_tx_beat) && $stable(core_tx_chan)
   ) else $error("tx beat changed under back-pressure");

endmodule

/* tb_sonic_top.sv */
// clock, reset, tx and rx stimulus, expected queues and checks for the VC layer top level
`timescale 1ns/10ps

module tb_sonic_top;

`include "sonic_defines.svh"

   localparam int TX_PKTS = 40;
   localparam int RX_PKTS = 30;
   localparam int TIMEOUT = 2000;
   localparam int DEPTH   = `SONIC_TX_FIFO_DEPTH;
   localparam int CREDITS = `SONIC_RX_PORT_CREDITS;

   logic                           pld_clk;
   logic                           rst_n;
   logic [1:0]                     tx_port_valid;
   sonic_stream_pkg::stream_beat_t tx_port_beat0;
   sonic_stream_pkg::stream_beat_t tx_port_beat1;
   logic [1:0]                     tx_credit;
   sonic_stream_pkg::stream_beat_t core_tx_beat;
   logic                           core_tx_valid;
   sonic_link_pkg::port_id_t       core_tx_chan;
   logic                           core_tx_ready;
   sonic_stream_pkg::stream_beat_t core_rx_beat;
   logic                           core_rx_valid;
   logic                           core_rx_ready;
   sonic_stream_pkg::stream_beat_t rx_port_beat;
   logic [1:0]                     rx_port_valid;
   sonic_link_pkg::credit_ret_t    rx_credit;

   sonic_stream_pkg::stream_beat_t exp_tx0[$];
   sonic_stream_pkg::stream_beat_t exp_tx1[$];
   sonic_stream_pkg::stream_beat_t exp_rx0[$];
   sonic_stream_pkg::stream_beat_t exp_rx1[$];

   int errors;
   int timeouts;
   int checks;
   int credits[2];   // tx credits each port holds
   int pushed[2];
   int written[2];   // beats already inside the tx buffer
   int popped[2];
   int rx_out[2];    // delivered but not yet returned
   int rx_pend[2];   // returns still owed to the router
   int rx_seq;
   logic [1:0] hold_credit;
   logic open_pkt;
   logic have_last;
   logic tx_done;
   logic rx_busy;
   sonic_link_pkg::port_id_t open_chan;
   sonic_link_pkg::port_id_t last_chan;

   sonic_top DUT (.*);

   always #50 pld_clk = ~pld_clk;

   function automatic sonic_stream_pkg::stream_beat_t make_beat(
      logic [`SONIC_DATA_W-1:0] data, logic sop, logic eop);
      sonic_stream_pkg::stream_beat_t b;
      b      = '0;
      b.data = data;
      b.sop  = sop;
      b.eop  = eop;
      return b;
   endfunction

   task automatic compare_beat(string name, sonic_stream_pkg::stream_beat_t exp,
                               sonic_stream_pkg::stream_beat_t got);
      checks++;
      if (exp !== got) begin
         errors++;
         $display("MISMATCH %s exp=%h got=%h", name, exp, got);
      end
   endtask

   task automatic note_timeout(string what);
      timeouts++;
      $display("timeout while waiting for %s", what);
   endtask

   // stalled beat held steady
   a_tx_stall: assert property (@(posedge pld_clk) disable iff (!rst_n)
      core_tx_valid && !core_tx_ready |=>
         core_tx_valid && $stable(core_tx_beat) && $stable(core_tx_chan))
      else begin
         errors++;
         $display("core tx beat or channel changed while the core stalled");
      end

   a_reset_idle: assert property (@(posedge pld_clk)
      !rst_n |=> !core_tx_valid && rx_port_valid == 2'b00 && tx_credit == 2'b00)
      else begin
         errors++;
         $display("outputs active right after reset");
      end

   // core tx monitor
   always @(posedge pld_clk) begin
      int other;
      sonic_stream_pkg::stream_beat_t exp;
      if (rst_n) begin
         for (int p = 0; p < 2; p++) begin
            if (tx_credit[p]) credits[p]++;
         end
         if (core_tx_valid && !open_pkt) begin
            other = core_tx_chan ? 0 : 1;
            a_alternate: assert (!(have_last && core_tx_chan == last_chan &&
                                   written[other] > popped[other]))
               else begin
                  errors++;
                  $display("port %0d won twice while port %0d waited", core_tx_chan, other);
               end
            open_pkt  = 1'b1;
            open_chan = core_tx_chan;
         end
         if (core_tx_valid && core_tx_chan != open_chan) begin
            errors++;
            $display("MISMATCH core_tx_chan exp=%h got=%h", open_chan, core_tx_chan);
         end
         if (core_tx_valid && core_tx_ready) begin
            if ((core_tx_chan ? exp_tx1.size() : exp_tx0.size()) == 0) begin
               errors++;
               $display("core tx beat with nothing pending on port %0d", core_tx_chan);
            end else begin
               exp = core_tx_chan ? exp_tx1.pop_front() : exp_tx0.pop_front();
               compare_beat("core_tx_beat", exp, core_tx_beat);
            end
            popped[core_tx_chan]++;
            if (core_tx_beat.eop) begin
               open_pkt  = 1'b0;
               have_last = 1'b1;
               last_chan = core_tx_chan;
            end
         end
         written[0] = pushed[0];  // driven last cycle, stored at this edge
         written[1] = pushed[1];
      end
   end

   // rx port monitor
   always @(posedge pld_clk) begin
      sonic_stream_pkg::stream_beat_t exp;
      if (rst_n) begin
         for (int p = 0; p < 2; p++) begin
            if (rx_port_valid[p]) begin
               if ((p ? exp_rx1.size() : exp_rx0.size()) == 0) begin
                  errors++;
                  $display("unexpected beat at rx port %0d", p);
               end else begin
                  exp = p ? exp_rx1.pop_front() : exp_rx0.pop_front();
                  compare_beat(p ? "rx_port_beat(1)" : "rx_port_beat(0)", exp, rx_port_beat);
               end
               rx_out[p]++;
               rx_pend[p]++;
            end
            a_rx_credit: assert (rx_out[p] <= CREDITS)
               else begin
                  errors++;
                  $display("rx port %0d got more beats than its credits", p);
               end
         end
      end
   end

   // rx credit returned at one beat per cycle per port
   always @(posedge pld_clk) begin
      #1;
      rx_credit = '0;
      if (rst_n && !hold_credit[0] && rx_pend[0] > 0) begin
         rx_credit.port0 = 1'b1;
         rx_pend[0]--;
         rx_out[0]--;
      end
      if (rst_n && !hold_credit[1] && rx_pend[1] > 0) begin
         rx_credit.port1 = 1'b1;
         rx_pend[1]--;
         rx_out[1]--;
      end
   end

   task automatic run_tx();
      int left[2];
      int rem[2];
      int len[2];
      int gap[2];
      int seq[2];
      int t;
      sonic_stream_pkg::stream_beat_t b;
      for (int p = 0; p < 2; p++) begin
         left[p] = TX_PKTS;
         rem[p]  = 0;
         gap[p]  = 0;
         seq[p]  = 0;
      end
      t = 0;
      while (left[0] + left[1] + rem[0] + rem[1] > 0 && t < 4 * TIMEOUT) begin
         @(posedge pld_clk);
         #1;
         t++;
         tx_port_valid = '0;
         for (int p = 0; p < 2; p++) begin
            if (rem[p] == 0) begin
               if (gap[p] > 0) begin
                  gap[p]--;
               end else if (left[p] > 0) begin
                  len[p] = 1 + $urandom % 4;
                  rem[p] = len[p];
                  left[p]--;
               end
            end
            if (rem[p] > 0 && credits[p] > 0) begin
               b = make_beat({8'(p), 24'(seq[p]), 32'($urandom), 32'($urandom),
                              32'($urandom)}, rem[p] == len[p], rem[p] == 1);
               if (p == 0) begin
                  tx_port_beat0 = b;
                  exp_tx0.push_back(b);
               end else begin
                  tx_port_beat1 = b;
                  exp_tx1.push_back(b);
               end
               tx_port_valid[p] = 1'b1;
               credits[p]--;
               pushed[p]++;
               seq[p]++;
               rem[p]--;
               if (rem[p] == 0) gap[p] = $urandom % 3;
            end
         end
      end
      if (left[0] + left[1] + rem[0] + rem[1] > 0) note_timeout("tx ports to push all packets");
      @(posedge pld_clk);
      #1;
      tx_port_valid = '0;
      t = 0;
      while ((exp_tx0.size() + exp_tx1.size() > 0 || credits[0] != DEPTH ||
              credits[1] != DEPTH) && t < TIMEOUT) begin
         @(posedge pld_clk);
         t++;
      end
      if (t >= TIMEOUT) note_timeout("tx drain and credit return");
      tx_done = 1'b1;
   endtask

   task automatic drive_ready();
      int n;
      n = 0;
      while (!tx_done && n < 100000) begin
         @(posedge pld_clk);
         #1;
         core_tx_ready = ($urandom % 4) != 0;  // about one stall in four
         n++;
      end
      core_tx_ready = 1'b1;
   endtask

   // caller sits 1 ns after an edge
   task automatic send_rx_pkt(logic [4:0] typ, int len);
      sonic_stream_pkg::tlp_dw0_u dw0;
      sonic_stream_pkg::stream_beat_t b;
      logic dest;
      int t;
      dw0          = '0;
      dw0.hdr.fmt  = 3'b010;
      dw0.hdr.tlp_type = typ;
      dw0.hdr.length   = 10'(len * 4);
      dest = (typ == 5'd5);
      for (int i = 0; i < len; i++) begin
         b = make_beat({32'(rx_seq), 32'($urandom), 32'($urandom),
                        (i == 0) ? dw0.raw : 32'($urandom)}, i == 0, i == len - 1);
         rx_seq++;
         core_rx_beat  = b;
         core_rx_valid = 1'b1;
         t = 0;
         do begin
            @(posedge pld_clk);
            t++;
         end while (!core_rx_ready && t < TIMEOUT);
         if (!core_rx_ready) note_timeout("core_rx_ready");
         if (dest) exp_rx1.push_back(b);
         else exp_rx0.push_back(b);
         #1;
      end
      core_rx_valid = 1'b0;
   endtask

   task automatic run_rx();
      logic [4:0] typ;
      for (int i = 0; i < RX_PKTS; i++) begin
         typ = ($urandom % 2) ? 5'd5 : 5'($urandom);
         send_rx_pkt(typ, 1 + $urandom % 4);
         repeat ($urandom % 3) begin
            @(posedge pld_clk);
            #1;
         end
      end
   endtask

   task automatic send_held();
      rx_busy = 1'b1;
      repeat (3) send_rx_pkt(5'd0, 4);
      rx_busy = 1'b0;
   endtask

   task automatic wait_rx_idle();
      int t;
      t = 0;
      while ((exp_rx0.size() + exp_rx1.size() > 0 || rx_out[0] + rx_out[1] > 0 || rx_busy)
             && t < TIMEOUT) begin
         @(posedge pld_clk);
         t++;
      end
      if (t >= TIMEOUT) note_timeout("rx traffic to drain");
   endtask

   task automatic end_run();
      $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   endtask

   initial begin
      int t;
      void'($urandom(99635));
      pld_clk       = 1'b0;
      rst_n         = 1'b0;
      tx_port_valid = '0;
      tx_port_beat0 = '0;
      tx_port_beat1 = '0;
      core_tx_ready = 1'b1;
      core_rx_beat  = '0;
      core_rx_valid = 1'b0;
      rx_credit     = '0;
      hold_credit   = '0;
      open_pkt      = 1'b0;
      have_last     = 1'b0;
      open_chan     = 1'b0;
      last_chan     = 1'b0;
      tx_done       = 1'b0;
      rx_busy       = 1'b0;
      credits[0]    = DEPTH;
      credits[1]    = DEPTH;
      repeat (3) @(posedge pld_clk);
      #1;
      rst_n = 1'b1;

      fork
         run_tx();
         drive_ready();
         run_rx();
      join
      wait_rx_idle();
      @(posedge pld_clk);
      #1;

      // withhold port 0 credit until the router stalls
      hold_credit[0] = 1'b1;
      fork
         send_held();
      join_none
      t = 0;
      while (!(rx_out[0] == CREDITS && core_rx_valid && !core_rx_ready) && t < TIMEOUT) begin
         @(posedge pld_clk);
         t++;
      end
      if (t >= TIMEOUT) note_timeout("core_rx_ready to fall with port 0 out of credit");
      else checks++;
      repeat (5) @(posedge pld_clk);
      #1;
      hold_credit[0] = 1'b0;
      wait_rx_idle();
      end_run();
   end

endmodule
